// ==== rtl/i2s_cfg_pkg.sv ====
// I2S configuration register definitions
package i2s_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int unsigned L2_AWIDTH    = 12;
    localparam int unsigned TRANS_SIZE   = 16;
    localparam int unsigned REG_ADDR_W   = 5;
    localparam int unsigned CHAN_LOCAL_W = 2;

    // Register word addresses
    localparam logic [REG_ADDR_W-1:0] ADDR_RX_SADDR  = 5'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_RX_SIZE   = 5'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_RX_CFG    = 5'd2;
    localparam logic [REG_ADDR_W-1:0] ADDR_TX_SADDR  = 5'd4;
    localparam logic [REG_ADDR_W-1:0] ADDR_TX_SIZE   = 5'd5;
    localparam logic [REG_ADDR_W-1:0] ADDR_TX_CFG    = 5'd6;
    localparam logic [REG_ADDR_W-1:0] ADDR_CLK_SETUP = 5'd8;
    localparam logic [REG_ADDR_W-1:0] ADDR_SLV_SETUP = 5'd9;
    localparam logic [REG_ADDR_W-1:0] ADDR_MST_SETUP = 5'd10;

    // Local register index inside a channel
    localparam logic [CHAN_LOCAL_W-1:0] LIDX_SADDR = 2'd0;
    localparam logic [CHAN_LOCAL_W-1:0] LIDX_SIZE  = 2'd1;
    localparam logic [CHAN_LOCAL_W-1:0] LIDX_CFG   = 2'd2;

    // Audio setup select
    localparam logic [1:0] SETUP_SEL_CLK = 2'd0;
    localparam logic [1:0] SETUP_SEL_SLV = 2'd1;
    localparam logic [1:0] SETUP_SEL_MST = 2'd2;

    localparam logic [1:0] DATASIZE_RST = 2'd2;

    // Channel config bit positions
    localparam int unsigned CFG_CLR_BIT   = 6;
    localparam int unsigned CFG_PEND_BIT  = 5;
    localparam int unsigned CFG_EN_BIT    = 4;
    localparam int unsigned CFG_DSIZE_LSB = 1;
    localparam int unsigned CFG_CONT_BIT  = 0;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                  valid;
        logic                  rwn;
        logic [REG_ADDR_W-1:0] addr;
        logic [31:0]           data;
    } cfg_req_t;

    typedef struct packed {
        logic [L2_AWIDTH-1:0]  startaddr;
        logic [TRANS_SIZE-1:0] size;
        logic [1:0]            datasize;
        logic                  continuous;
        logic                  en;
        logic                  clr;
    } chan_cfg_t;

    typedef struct packed {
        logic                  en;
        logic                  pending;
        logic [L2_AWIDTH-1:0]  curr_addr;
        logic [TRANS_SIZE-1:0] bytes_left;
    } chan_status_t;

    typedef struct packed {
        logic       en;
        logic       lsb_first;
        logic       two_ch;
        logic [4:0] bits_word;
        logic [3:0] words;
    } i2s_setup_t;

    // Dividers are common byte over own byte
    typedef struct packed {
        logic        master_sel_num;
        logic        master_sel_ext;
        logic        slave_sel_num;
        logic        slave_sel_ext;
        logic        master_clk_en;
        logic        slave_clk_en;
        logic [15:0] master_gen_clk_div;
        logic [15:0] slave_gen_clk_div;
    } clk_setup_t;

endpackage

// ==== rtl/udma_chan_regs.sv ====
// uDMA channel registers
`timescale 1ns/1ps

module udma_chan_regs (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,
    input  logic                                 we_i,
    input  logic [i2s_cfg_pkg::CHAN_LOCAL_W-1:0] local_idx_i,
    input  logic [31:0]                          wdata_i,
    input  i2s_cfg_pkg::chan_status_t            status_i,
    output i2s_cfg_pkg::chan_cfg_t               cfg_o,
    output logic [31:0]                          rdata_o
);

    i2s_cfg_pkg::chan_cfg_t r_cfg;
    logic                   cfg_we;
    logic                   en_set;
    logic                   clr_set;

    assign cfg_we  = we_i && (local_idx_i == i2s_cfg_pkg::LIDX_CFG);
    assign en_set  = cfg_we && wdata_i[i2s_cfg_pkg::CFG_EN_BIT];
    assign clr_set = cfg_we && wdata_i[i2s_cfg_pkg::CFG_CLR_BIT];

    assign cfg_o = r_cfg;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_cfg.startaddr  <= '0;
            r_cfg.size       <= '0;
            r_cfg.datasize   <= i2s_cfg_pkg::DATASIZE_RST;
            r_cfg.continuous <= 1'b0;
            r_cfg.en         <= 1'b0;
            r_cfg.clr        <= 1'b0;
        end
        else
        begin
            // Single-cycle pulses
            r_cfg.en  <= en_set;
            r_cfg.clr <= clr_set;

            if (we_i && (local_idx_i == i2s_cfg_pkg::LIDX_SADDR))
                r_cfg.startaddr <= wdata_i[i2s_cfg_pkg::L2_AWIDTH-1:0];
            if (we_i && (local_idx_i == i2s_cfg_pkg::LIDX_SIZE))
                r_cfg.size <= wdata_i[i2s_cfg_pkg::TRANS_SIZE-1:0];
            if (cfg_we)
            begin
                r_cfg.datasize   <= wdata_i[i2s_cfg_pkg::CFG_DSIZE_LSB +: 2];
                r_cfg.continuous <= wdata_i[i2s_cfg_pkg::CFG_CONT_BIT];
            end
        end
    end

    // Status readback from the DMA side
    always_comb
    begin
        rdata_o = '0;
        case (local_idx_i)
            i2s_cfg_pkg::LIDX_SADDR:
                rdata_o[i2s_cfg_pkg::L2_AWIDTH-1:0] = status_i.curr_addr;
            i2s_cfg_pkg::LIDX_SIZE:
                rdata_o[i2s_cfg_pkg::TRANS_SIZE-1:0] = status_i.bytes_left;
            i2s_cfg_pkg::LIDX_CFG:
            begin
                rdata_o[i2s_cfg_pkg::CFG_CLR_BIT]        = r_cfg.clr;
                rdata_o[i2s_cfg_pkg::CFG_PEND_BIT]       = status_i.pending;
                rdata_o[i2s_cfg_pkg::CFG_EN_BIT]         = status_i.en;
                rdata_o[i2s_cfg_pkg::CFG_DSIZE_LSB +: 2] = r_cfg.datasize;
                rdata_o[i2s_cfg_pkg::CFG_CONT_BIT]       = r_cfg.continuous;
            end
            default:
                rdata_o = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Interface checks
    ////////////////////////////////////////////////////////////
    // Bus never strobes the unused local index
    a_we_idx: assert property (@(posedge clk_i) disable iff (!rstn_i)
        we_i |-> (local_idx_i <= i2s_cfg_pkg::LIDX_CFG));

endmodule

// ==== rtl/i2s_audio_setup_regs.sv ====
// I2S clock and audio setup registers
`timescale 1ns/1ps

module i2s_audio_setup_regs (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    we_i,
    input  logic [1:0]              setup_sel_i,
    input  logic [31:0]             wdata_i,
    output i2s_cfg_pkg::clk_setup_t clk_setup_o,
    output i2s_cfg_pkg::i2s_setup_t slave_setup_o,
    output i2s_cfg_pkg::i2s_setup_t master_setup_o,
    output logic [31:0]             rdata_o
);

    logic [3:0]              r_clk_sel;
    logic                    r_master_clk_en;
    logic                    r_slave_clk_en;
    logic [7:0]              r_common_div;
    logic [7:0]              r_slave_div;
    logic [7:0]              r_master_div;
    i2s_cfg_pkg::i2s_setup_t r_slave_setup;
    i2s_cfg_pkg::i2s_setup_t r_master_setup;

    // Same field layout for slave and master
    function automatic i2s_cfg_pkg::i2s_setup_t setup_from_word(input logic [31:0] w);
        i2s_cfg_pkg::i2s_setup_t s;
        s.en        = w[31];
        s.two_ch    = w[17];
        s.lsb_first = w[16];
        s.bits_word = w[12:8];
        s.words     = w[3:0];
        return s;
    endfunction

    function automatic logic [31:0] setup_to_word(input i2s_cfg_pkg::i2s_setup_t s);
        return {s.en, 13'h0, s.two_ch, s.lsb_first, 3'h0, s.bits_word, 4'h0, s.words};
    endfunction

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_clk_sel       <= '0;
            r_master_clk_en <= 1'b0;
            r_slave_clk_en  <= 1'b0;
            r_common_div    <= '0;
            r_slave_div     <= '0;
            r_master_div    <= '0;
            r_slave_setup   <= '0;
            r_master_setup  <= '0;
        end
        else if (we_i)
        begin
            case (setup_sel_i)
                i2s_cfg_pkg::SETUP_SEL_CLK:
                begin
                    r_clk_sel       <= wdata_i[31:28];
                    r_master_clk_en <= wdata_i[25];
                    r_slave_clk_en  <= wdata_i[24];
                    r_common_div    <= wdata_i[23:16];
                    r_slave_div     <= wdata_i[15:8];
                    r_master_div    <= wdata_i[7:0];
                end
                i2s_cfg_pkg::SETUP_SEL_SLV: r_slave_setup  <= setup_from_word(wdata_i);
                i2s_cfg_pkg::SETUP_SEL_MST: r_master_setup <= setup_from_word(wdata_i);
                default: ;
            endcase
        end
    end

    assign clk_setup_o.master_sel_num     = r_clk_sel[3];
    assign clk_setup_o.master_sel_ext     = r_clk_sel[2];
    assign clk_setup_o.slave_sel_num      = r_clk_sel[1];
    assign clk_setup_o.slave_sel_ext      = r_clk_sel[0];
    assign clk_setup_o.master_clk_en      = r_master_clk_en;
    assign clk_setup_o.slave_clk_en       = r_slave_clk_en;
    assign clk_setup_o.master_gen_clk_div = {r_common_div, r_master_div};
    assign clk_setup_o.slave_gen_clk_div  = {r_common_div, r_slave_div};

    assign slave_setup_o  = r_slave_setup;
    assign master_setup_o = r_master_setup;

    always_comb
    begin
        case (setup_sel_i)
            i2s_cfg_pkg::SETUP_SEL_CLK:
                rdata_o = {r_clk_sel, 2'b00, r_master_clk_en, r_slave_clk_en,
                           r_common_div, r_slave_div, r_master_div};
            i2s_cfg_pkg::SETUP_SEL_SLV: rdata_o = setup_to_word(r_slave_setup);
            i2s_cfg_pkg::SETUP_SEL_MST: rdata_o = setup_to_word(r_master_setup);
            default:                    rdata_o = '0;
        endcase
    end

endmodule

// ==== rtl/i2s_cfg_bus.sv ====
// Register bus decoder
`timescale 1ns/1ps

module i2s_cfg_bus (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,
    input  i2s_cfg_pkg::cfg_req_t                cfg_req_i,
    output logic [31:0]                          cfg_data_o,
    output logic                                 cfg_ready_o,
    output logic                                 rx_we_o,
    output logic                                 tx_we_o,
    output logic                                 setup_we_o,
    output logic [i2s_cfg_pkg::CHAN_LOCAL_W-1:0] local_idx_o,
    output logic [1:0]                           setup_sel_o,
    output logic [31:0]                          wdata_o,
    input  logic [31:0]                          rx_rdata_i,
    input  logic [31:0]                          tx_rdata_i,
    input  logic [31:0]                          setup_rdata_i
);

    logic rx_hit;
    logic tx_hit;
    logic setup_hit;
    logic wr;
    logic rd;

    assign wr = cfg_req_i.valid && !cfg_req_i.rwn;
    assign rd = cfg_req_i.valid && cfg_req_i.rwn;

    // Full address decode lives here only
    always_comb
    begin
        rx_hit      = 1'b0;
        tx_hit      = 1'b0;
        setup_hit   = 1'b0;
        setup_sel_o = i2s_cfg_pkg::SETUP_SEL_CLK;
        case (cfg_req_i.addr)
            i2s_cfg_pkg::ADDR_RX_SADDR,
            i2s_cfg_pkg::ADDR_RX_SIZE,
            i2s_cfg_pkg::ADDR_RX_CFG:    rx_hit = 1'b1;
            i2s_cfg_pkg::ADDR_TX_SADDR,
            i2s_cfg_pkg::ADDR_TX_SIZE,
            i2s_cfg_pkg::ADDR_TX_CFG:    tx_hit = 1'b1;
            i2s_cfg_pkg::ADDR_CLK_SETUP: setup_hit = 1'b1;
            i2s_cfg_pkg::ADDR_SLV_SETUP:
            begin
                setup_hit   = 1'b1;
                setup_sel_o = i2s_cfg_pkg::SETUP_SEL_SLV;
            end
            i2s_cfg_pkg::ADDR_MST_SETUP:
            begin
                setup_hit   = 1'b1;
                setup_sel_o = i2s_cfg_pkg::SETUP_SEL_MST;
            end
            default: ;
        endcase
    end

    assign local_idx_o = cfg_req_i.addr[i2s_cfg_pkg::CHAN_LOCAL_W-1:0];
    assign wdata_o     = cfg_req_i.data;
    assign rx_we_o     = wr && rx_hit;
    assign tx_we_o     = wr && tx_hit;
    assign setup_we_o  = wr && setup_hit;
    assign cfg_ready_o = 1'b1;

    // Zero when idle or unmapped
    assign cfg_data_o = !rd      ? 32'h0 :
                        rx_hit    ? rx_rdata_i :
                        tx_hit    ? tx_rdata_i :
                        setup_hit ? setup_rdata_i : 32'h0;

    a_addr_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cfg_req_i.valid |-> !$isunknown(cfg_req_i.addr));

endmodule

// ==== rtl/i2s_reg_if.sv ====
// I2S configuration register block
`timescale 1ns/1ps

module i2s_reg_if (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  i2s_cfg_pkg::cfg_req_t     cfg_req_i,
    output logic [31:0]               cfg_data_o,
    output logic                      cfg_ready_o,
    output i2s_cfg_pkg::chan_cfg_t    rx_cfg_o,
    output i2s_cfg_pkg::chan_cfg_t    tx_cfg_o,
    input  i2s_cfg_pkg::chan_status_t rx_status_i,
    input  i2s_cfg_pkg::chan_status_t tx_status_i,
    output i2s_cfg_pkg::clk_setup_t   clk_setup_o,
    output i2s_cfg_pkg::i2s_setup_t   slave_setup_o,
    output i2s_cfg_pkg::i2s_setup_t   master_setup_o
);

    logic                                 rx_we;
    logic                                 tx_we;
    logic                                 setup_we;
    logic [i2s_cfg_pkg::CHAN_LOCAL_W-1:0] local_idx;
    logic [1:0]                           setup_sel;
    logic [31:0]                          wdata;
    logic [31:0]                          rx_rdata;
    logic [31:0]                          tx_rdata;
    logic [31:0]                          setup_rdata;

    i2s_cfg_bus u_bus (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cfg_req_i     (cfg_req_i),
        .cfg_data_o    (cfg_data_o),
        .cfg_ready_o   (cfg_ready_o),
        .rx_we_o       (rx_we),
        .tx_we_o       (tx_we),
        .setup_we_o    (setup_we),
        .local_idx_o   (local_idx),
        .setup_sel_o   (setup_sel),
        .wdata_o       (wdata),
        .rx_rdata_i    (rx_rdata),
        .tx_rdata_i    (tx_rdata),
        .setup_rdata_i (setup_rdata)
    );

    ////////////////////////////////////////////////////////////
    // DMA channels
    ////////////////////////////////////////////////////////////
    udma_chan_regs u_rx_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .we_i        (rx_we),
        .local_idx_i (local_idx),
        .wdata_i     (wdata),
        .status_i    (rx_status_i),
        .cfg_o       (rx_cfg_o),
        .rdata_o     (rx_rdata)
    );

    udma_chan_regs u_tx_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .we_i        (tx_we),
        .local_idx_i (local_idx),
        .wdata_i     (wdata),
        .status_i    (tx_status_i),
        .cfg_o       (tx_cfg_o),
        .rdata_o     (tx_rdata)
    );

    // Clock and I2S setup
    i2s_audio_setup_regs u_setup_regs (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .we_i           (setup_we),
        .setup_sel_i    (setup_sel),
        .wdata_i        (wdata),
        .clk_setup_o    (clk_setup_o),
        .slave_setup_o  (slave_setup_o),
        .master_setup_o (master_setup_o),
        .rdata_o        (setup_rdata)
    );

endmodule

// ==== tests/tb_i2s_reg_if.sv ====
// I2S register block testbench
`timescale 1ns/1ps

module tb_i2s_reg_if;

    localparam int READY_TIMEOUT = 20;
    localparam int MAX_OPS       = 500;

    logic                      clk;
    logic                      rstn;
    i2s_cfg_pkg::cfg_req_t     cfg_req;
    logic [31:0]               cfg_data;
    logic                      cfg_ready;
    i2s_cfg_pkg::chan_cfg_t    rx_cfg;
    i2s_cfg_pkg::chan_cfg_t    tx_cfg;
    i2s_cfg_pkg::chan_status_t rx_status;
    i2s_cfg_pkg::chan_status_t tx_status;
    i2s_cfg_pkg::clk_setup_t   clk_setup;
    i2s_cfg_pkg::i2s_setup_t   slave_setup;
    i2s_cfg_pkg::i2s_setup_t   master_setup;

    int          fd;
    int          code;
    int          n_ops;
    logic        done;
    logic [7:0]  op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;

    i2s_reg_if UUT (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .cfg_req_i      (cfg_req),
        .cfg_data_o     (cfg_data),
        .cfg_ready_o    (cfg_ready),
        .rx_cfg_o       (rx_cfg),
        .tx_cfg_o       (tx_cfg),
        .rx_status_i    (rx_status),
        .tx_status_i    (tx_status),
        .clk_setup_o    (clk_setup),
        .slave_setup_o  (slave_setup),
        .master_setup_o (master_setup)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Simulation failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Ready is sampled 1 ns after the inputs change
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        #1;
        while (cfg_ready !== 1'b1)
        begin
            cycles++;
            if (cycles > READY_TIMEOUT)
                abort_run("timeout while waiting for cfg_ready_o");
            else
            begin
                @(posedge clk);
                #1.5;
            end
        end
    endtask

    // Output fields picked by a selector from the data file
    task automatic sample_output(input logic [4:0] sel, output logic [31:0] val,
                                 output string name);
        val = '0;
        case (sel)
            5'd0:
            begin
                val  = {20'h0, rx_cfg.startaddr};
                name = "rx_cfg_o.startaddr";
            end
            5'd1:
            begin
                val  = {16'h0, rx_cfg.size};
                name = "rx_cfg_o.size";
            end
            5'd2:
            begin
                val  = {27'h0, rx_cfg.datasize, rx_cfg.continuous, rx_cfg.en, rx_cfg.clr};
                name = "rx_cfg_o flags";
            end
            5'd4:
            begin
                val  = {20'h0, tx_cfg.startaddr};
                name = "tx_cfg_o.startaddr";
            end
            5'd5:
            begin
                val  = {16'h0, tx_cfg.size};
                name = "tx_cfg_o.size";
            end
            5'd6:
            begin
                val  = {27'h0, tx_cfg.datasize, tx_cfg.continuous, tx_cfg.en, tx_cfg.clr};
                name = "tx_cfg_o flags";
            end
            5'd8:
            begin
                val  = {26'h0, clk_setup.master_sel_num, clk_setup.master_sel_ext,
                        clk_setup.slave_sel_num, clk_setup.slave_sel_ext,
                        clk_setup.master_clk_en, clk_setup.slave_clk_en};
                name = "clk_setup_o flags";
            end
            5'd9:
            begin
                val  = {20'h0, slave_setup};
                name = "slave_setup_o";
            end
            5'd10:
            begin
                val  = {20'h0, master_setup};
                name = "master_setup_o";
            end
            5'd11:
            begin
                val  = {16'h0, clk_setup.master_gen_clk_div};
                name = "clk_setup_o.master_gen_clk_div";
            end
            5'd12:
            begin
                val  = {16'h0, clk_setup.slave_gen_clk_div};
                name = "clk_setup_o.slave_gen_clk_div";
            end
            default:
                abort_run("unknown output selector in stimulus file");
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // One stimulus line per clock cycle
    ////////////////////////////////////////////////////////////
    task automatic apply_op(input logic [7:0] code_op, input logic [31:0] a,
                            input logic [31:0] d, input logic [31:0] e);
        logic [31:0] val;
        string       name;
        @(posedge clk);
        #0.5;
        cfg_req = '0;
        case (code_op)
            "W":
            begin
                cfg_req.valid = 1'b1;
                cfg_req.rwn   = 1'b0;
                cfg_req.addr  = a[i2s_cfg_pkg::REG_ADDR_W-1:0];
                cfg_req.data  = d;
                wait_ready();
            end
            "R":
            begin
                cfg_req.valid = 1'b1;
                cfg_req.rwn   = 1'b1;
                cfg_req.addr  = a[i2s_cfg_pkg::REG_ADDR_W-1:0];
                wait_ready();
                check_value($sformatf("cfg_data_o[0x%02h]", a[4:0]), cfg_data, e);
            end
            "O":
            begin
                #1;
                sample_output(a[4:0], val, name);
                check_value(name, val, e);
            end
            "S":
            begin
                if (a == 32'd0)
                    rx_status = d[29:0];
                else if (a == 32'd1)
                    tx_status = d[29:0];
                else
                    abort_run("bad status target in stimulus file");
            end
            default:
                abort_run("unknown operation code in stimulus file");
        endcase
    endtask

    // Comment lines start with a lone # token
    task automatic skip_line();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1)
            c = $fgetc(fd);
    endtask

    initial
    begin
        clk       = 1'b0;
        rstn      = 1'b0;
        cfg_req   = '0;
        rx_status = '0;
        tx_status = '0;
        n_ops     = 0;
        done      = 1'b0;

        fd = $fopen("tests/i2s_stimulus.txt", "r");
        if (fd == 0)
            abort_run("could not open tests/i2s_stimulus.txt");

        repeat (16) @(posedge clk);
        #0.5;
        rstn = 1'b1;

        while (!done)
        begin
            code = $fscanf(fd, "%s", op);
            if (code != 1)
                done = 1'b1;
            else if (op == "#")
                skip_line();
            else if (n_ops >= MAX_OPS)
                abort_run("stimulus file holds too many operations");
            else
            begin
                code = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
                if (code != 3)
                    abort_run("malformed line in stimulus file");
                else
                begin
                    n_ops++;
                    apply_op(op, f_addr, f_data, f_exp);
                end
            end
        end
        $fclose(fd);

        if (n_ops == 0)
            abort_run("no operations found in stimulus file");
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== tests/i2s_stimulus.txt ====
# columns: op addr data expected, all hex
# op: W write, R read-check, O output-check (addr = selector), S status-set (0 rx, 1 tx)
# reset values
R 00 00000000 00000000
R 02 00000000 00000004
R 06 00000000 00000004
R 08 00000000 00000000
R 0A 00000000 00000000
O 02 00000000 00000010
O 06 00000000 00000010
O 08 00000000 00000000
# setup registers all ones
W 08 FFFFFFFF 00000000
W 09 FFFFFFFF 00000000
W 0A FFFFFFFF 00000000
R 08 00000000 F3FFFFFF
R 09 00000000 80031F0F
R 0A 00000000 80031F0F
O 08 00000000 0000003F
O 09 00000000 00000FFF
O 0A 00000000 00000FFF
O 0B 00000000 0000FFFF
# setup registers distinct fields
W 08 9D123456 00000000
W 09 80010A05 00000000
R 08 00000000 91123456
R 09 00000000 80010A05
O 08 00000000 00000025
O 09 00000000 00000CA5
O 0B 00000000 00001256
O 0C 00000000 00001234
# enable and clear pulses
W 02 00000053 00000000
O 02 00000000 0000000F
O 02 00000000 0000000C
W 06 00000050 00000000
R 06 00000000 00000040
O 06 00000000 00000000
# status readback
S 00 2ABC1234 00000000
S 01 1123BEEF 00000000
R 00 00000000 00000ABC
R 01 00000000 00001234
R 02 00000000 00000013
R 04 00000000 00000123
R 05 00000000 0000BEEF
R 06 00000000 00000020
# start address and size per channel
W 00 FFFFF5A5 00000000
W 01 FFFF8765 00000000
O 00 00000000 000005A5
O 01 00000000 00008765
O 04 00000000 00000000
W 04 12345678 00000000
W 05 CAFE0042 00000000
O 04 00000000 00000678
O 05 00000000 00000042
O 00 00000000 000005A5
# unmapped addresses
R 03 00000000 00000000
R 07 00000000 00000000
R 0B 00000000 00000000
R 1F 00000000 00000000
W 03 FFFFFFFF 00000000
W 0B FFFFFFFF 00000000
W 1F FFFFFFFF 00000000
O 02 00000000 0000000C
O 00 00000000 000005A5
O 08 00000000 00000025

// ==== project.f ====
rtl/i2s_cfg_pkg.sv
rtl/udma_chan_regs.sv
rtl/i2s_audio_setup_regs.sv
rtl/i2s_cfg_bus.sv
rtl/i2s_reg_if.sv
tests/tb_i2s_reg_if.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_i2s_reg_if
FILELIST  := project.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
